// ==== hw/ret_pred_cfg.svh ====
/* sizing for the return predictor; include before the package or any
   module that needs the stack or checkpoint depths */

`ifndef RET_PRED_CFG_SVH
`define RET_PRED_CFG_SVH

// ----------------------------------------------------------------------
// return address stack

// number of stack entries, power of two
// pointer wraps silently on overflow and underflow
`define RAS_ENTRIES 8

// ----------------------------------------------------------------------
// checkpoint buffer

// in-flight calls and returns that can be restored
// power of two so tags wrap without extra logic
`define CKPT_ENTRIES 4

`endif

// ==== hw/ret_pred_pkg.sv ====
/* shared types and RV32I encodings for the return predictor blocks */

`include "ret_pred_cfg.svh"

package ret_pred_pkg;

    // ------------------------------------------------------------------
    // widths derived from the config header

    localparam int RAS_INDEX_WIDTH = $clog2(`RAS_ENTRIES);
    localparam int CKPT_TAG_WIDTH  = $clog2(`CKPT_ENTRIES);

    // stack pointer
    typedef logic [RAS_INDEX_WIDTH-1:0] ras_index_t;

    // checkpoint slot, wraps modulo depth
    typedef logic [CKPT_TAG_WIDTH-1:0] ckpt_tag_t;

    // return address without bit 0, always zero in RV32I without C
    typedef logic [31:1] ras_target_t;

    // predecode result
    typedef enum logic [1:0] {
        plain    = 2'd0,
        call     = 2'd1,
        ret      = 2'd2,
        call_ret = 2'd3
    } instr_class_t;

    // ------------------------------------------------------------------
    // encodings

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // link registers per the standard calling hints
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

endpackage

// ==== hw/ras_port_if.sv ====
/* push/pop port between the predecoder and the return address stack;
   the top level also taps link, ret and index for checkpointing */

`timescale 1ns/1ns

interface ras_port_if ();
    import ret_pred_pkg::*;

    // predecoder to stack
    logic        link;
    logic        ret;
    logic [31:0] link_pc;

    // stack to predecoder
    ras_target_t top_target;
    ras_index_t  index;

    // predecoder side
    modport predictor (
        output link,
        output ret,
        output link_pc,
        input  top_target
    );

    // stack side, index goes out for checkpointing
    modport stack (
        input  link,
        input  ret,
        input  link_pc,
        output top_target,
        output index
    );

endinterface

// ==== hw/ret_predecode.sv ====
/* fetch-response predecoder: spots calls and returns by link-register
   hints, drives stack push/pop and the same-cycle return prediction */

`timescale 1ns/1ns

module ret_predecode (
    // fetch response
    input  logic        [31:0] instr,
    input  logic        [31:0] fetch_pc,
    input  logic               fetch_valid,

    // stack port
    ras_port_if.predictor      rp,

    // prediction, combinational with fetch_valid
    output logic               pred_valid,
    output logic               pred_is_call,
    output logic               pred_is_ret,
    output logic        [31:0] pred_target
);
    import ret_pred_pkg::*;

    // ------------------------------------------------------------------
    // field extract

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [4:0]   rd;
    logic [4:0]   rs1;
    logic         is_jal;
    logic         is_jalr;
    logic         rd_link;
    logic         rs1_link;
    instr_class_t cls;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];

    assign is_jal  = (opcode == OPC_JAL);
    // jalr only defined with funct3 000
    assign is_jalr = (opcode == OPC_JALR) && (funct3 == 3'b000);

    // x1 or x5 count as link
    assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
    assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);

    // ------------------------------------------------------------------
    // classify

    always_comb begin
        cls = plain;
        if (is_jal) begin
            // jal never pops
            if (rd_link)
                cls = call;
        end
        else if (is_jalr) begin
            // both link and different: pop then push
            if (rd_link && rs1_link && (rd != rs1))
                cls = call_ret;
            // rd == rs1 link falls here, push only
            else if (rd_link)
                cls = call;
            else if (rs1_link)
                cls = ret;
        end
    end

    // ------------------------------------------------------------------
    // stack port and prediction

    assign rp.link    = fetch_valid && ((cls == call) || (cls == call_ret));
    assign rp.ret     = fetch_valid && ((cls == ret) || (cls == call_ret));
    // no compressed support, always +4
    assign rp.link_pc = fetch_pc + 32'd4;

    assign pred_valid   = rp.link || rp.ret;
    assign pred_is_call = rp.link;
    assign pred_is_ret  = rp.ret;

    // old top for returns, call_ret included
    assign pred_target = rp.ret ? {rp.top_target, 1'b0} : 32'd0;

endmodule

// ==== hw/ras.sv ====
/* return address stack: flip-flop array plus pointer, pushed and popped
   by the predecoder, pointer restored by the checkpoint buffer */

`timescale 1ns/1ns

`include "ret_pred_cfg.svh"

module ras (
    input  logic                   CLK,
    input  logic                   nRST,

    // push/pop from predecoder
    ras_port_if.stack              sp_if,

    // pointer restore from checkpoint buffer
    input  logic                   update_valid,
    input  ret_pred_pkg::ras_index_t update_index
);
    import ret_pred_pkg::*;

    // ------------------------------------------------------------------
    // state

    ras_target_t array_q [`RAS_ENTRIES];
    ras_target_t array_d [`RAS_ENTRIES];
    ras_index_t  sp;
    ras_index_t  sp_d;
    ras_index_t  sp_inc;

    // wraps modulo depth
    assign sp_inc = sp + 1'b1;

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            sp <= '0;
            for (int i = 0; i < `RAS_ENTRIES; i++) begin
                array_q[i] <= '0;
            end
        end
        else begin
            sp      <= sp_d;
            array_q <= array_d;
        end
    end

    // ------------------------------------------------------------------
    // next state

    always_comb begin
        // hold by default
        array_d = array_q;
        sp_d    = sp;

        // restore wins, same-cycle fetch is dropped
        // entries overwritten since the checkpoint stay as they are
        if (update_valid) begin
            sp_d = update_index;
        end
        // pop and push: overwrite top in place
        else if (sp_if.link && sp_if.ret) begin
            array_d[sp] = sp_if.link_pc[31:1];
        end
        // push above top
        else if (sp_if.link) begin
            array_d[sp_inc] = sp_if.link_pc[31:1];
            sp_d            = sp_inc;
        end
        // pop, entry left behind
        else if (sp_if.ret) begin
            sp_d = sp - 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // read side, always valid

    assign sp_if.top_target = array_q[sp];
    assign sp_if.index      = sp;

endmodule

// ==== hw/ras_ckpt_buf.sv ====
/* circular buffer of stack pointers saved per call or return; commit
   frees the oldest, a flush at a tag restores that pointer and rewinds */

`timescale 1ns/1ns

`include "ret_pred_cfg.svh"

module ras_ckpt_buf (
    input  logic                     CLK,
    input  logic                     nRST,

    // allocate on every call or return
    input  logic                     alloc,
    input  ret_pred_pkg::ras_index_t alloc_index,

    // back end
    input  logic                     commit,
    input  logic                     flush_valid,
    input  ret_pred_pkg::ckpt_tag_t  flush_tag,

    // to fetch side
    output ret_pred_pkg::ckpt_tag_t  alloc_tag,
    output logic                     ckpt_full,

    // pointer restore to the stack
    output logic                     update_valid,
    output ret_pred_pkg::ras_index_t update_index
);
    import ret_pred_pkg::*;

    // count needs one more bit than a tag to tell full from empty
    localparam int CNT_W = CKPT_TAG_WIDTH + 1;

    // ------------------------------------------------------------------
    // storage and pointers

    ras_index_t       slots [`CKPT_ENTRIES];
    ckpt_tag_t        head;
    ckpt_tag_t        head_d;
    ckpt_tag_t        tail;
    ckpt_tag_t        tail_d;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_d;
    logic             do_alloc;
    logic             do_free;

    // flush drops any same-cycle allocation
    assign do_alloc = alloc && !flush_valid;
    // commit on empty is ignored
    assign do_free  = commit && (count != '0);

    // slot payload, no reset
    always_ff @(posedge CLK) begin
        if (do_alloc)
            slots[tail] <= alloc_index;
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else begin
            head  <= head_d;
            tail  <= tail_d;
            count <= count_d;
        end
    end

    // ------------------------------------------------------------------
    // pointer update

    always_comb begin
        head_d  = head;
        tail_d  = tail;
        count_d = count;

        if (do_free)
            head_d = head + 1'b1;

        if (flush_valid) begin
            // keep the flushed slot, drop everything younger
            tail_d  = flush_tag + 1'b1;
            // live slots are head..flush_tag, modulo depth
            count_d = {1'b0, ckpt_tag_t'(tail_d - head_d)};
        end
        else begin
            if (do_alloc)
                tail_d = tail + 1'b1;
            count_d = count + CNT_W'(do_alloc) - CNT_W'(do_free);
        end
    end

    // ------------------------------------------------------------------
    // outputs

    assign alloc_tag = tail;
    assign ckpt_full = (count == CNT_W'(`CKPT_ENTRIES));

    // combinational read, stack loads it at the edge
    assign update_valid = flush_valid;
    assign update_index = slots[flush_tag];

endmodule

// ==== hw/ret_pred_top.sv ====
/* return prediction top: predecoder, return address stack and checkpoint
   buffer behind plain fetch-response and back-end ports */

`timescale 1ns/1ns

module ret_pred_top (
    input  logic                    CLK,
    input  logic                    nRST,

    // fetch response stage
    input  logic                    fetch_valid,
    input  logic             [31:0] fetch_pc,
    input  logic             [31:0] instr,

    // back end
    input  logic                    commit,
    input  logic                    flush_valid,
    input  ret_pred_pkg::ckpt_tag_t flush_tag,

    // prediction
    output logic                    pred_valid,
    output logic                    pred_is_call,
    output logic                    pred_is_ret,
    output logic             [31:0] pred_target,
    output ret_pred_pkg::ckpt_tag_t alloc_tag,
    output logic                    ckpt_full
);
    import ret_pred_pkg::*;

    // ------------------------------------------------------------------
    // internal wiring

    ras_port_if rp_if ();

    logic       alloc;
    logic       update_valid;
    ras_index_t update_index;

    // every call or return takes a checkpoint
    assign alloc = rp_if.link | rp_if.ret;

    // ------------------------------------------------------------------
    // blocks

    ret_predecode u_predecode (
        .instr        (instr),
        .fetch_pc     (fetch_pc),
        .fetch_valid  (fetch_valid),
        .rp           (rp_if.predictor),
        .pred_valid   (pred_valid),
        .pred_is_call (pred_is_call),
        .pred_is_ret  (pred_is_ret),
        .pred_target  (pred_target)
    );

    ras u_ras (
        .CLK          (CLK),
        .nRST         (nRST),
        .sp_if        (rp_if.stack),
        .update_valid (update_valid),
        .update_index (update_index)
    );

    // index saved is the pointer before this instruction
    ras_ckpt_buf u_ckpt (
        .CLK          (CLK),
        .nRST         (nRST),
        .alloc        (alloc),
        .alloc_index  (rp_if.index),
        .commit       (commit),
        .flush_valid  (flush_valid),
        .flush_tag    (flush_tag),
        .alloc_tag    (alloc_tag),
        .ckpt_full    (ckpt_full),
        .update_valid (update_valid),
        .update_index (update_index)
    );

endmodule

// ==== sim/ret_pred_props.sv ====
/* concurrent checks bound onto ret_pred_top: back-pressure, quiet reset,
   pointer restore on flush */

`timescale 1ns/1ns

module ret_pred_props (
    input logic                     CLK,
    input logic                     nRST,
    input logic                     pred_valid,
    input logic                     ckpt_full,
    input logic                     flush_valid,
    input ret_pred_pkg::ras_index_t ras_index,
    input ret_pred_pkg::ras_index_t saved_index
);

    // fetch side holds off calls and returns with no free slot
    a_no_alloc_full: assert property (@(posedge CLK) disable iff (!nRST)
        ckpt_full |-> !pred_valid)
        else $error("call or return presented while ckpt_full is high");

    a_quiet_reset: assert property (@(posedge CLK) !nRST |-> !pred_valid)
        else $error("pred_valid high during reset");

    // saved index lands in the pointer one edge later
    a_flush_restore: assert property (@(posedge CLK) disable iff (!nRST)
        flush_valid |=> (ras_index == $past(saved_index)))
        else $error("stack index not restored after flush");

endmodule

bind ret_pred_top ret_pred_props props (
    .CLK         (CLK),
    .nRST        (nRST),
    .pred_valid  (pred_valid),
    .ckpt_full   (ckpt_full),
    .flush_valid (flush_valid),
    .ras_index   (rp_if.index),
    .saved_index (update_index)
);

// ==== sim/ret_pred_tb.sv ====
/* testbench for ret_pred_top: rows of fetch, flush and commit are applied
   in a loop and checked against a reference stack and checkpoint model */

`timescale 1ns/1ns

`include "ret_pred_cfg.svh"

module ret_pred_tb;
    import ret_pred_pkg::*;

    localparam int OP_FETCH   = 0;
    localparam int OP_FLUSH   = 1;
    localparam int OP_COMMIT  = 2;
    localparam int MAX_ROWS   = 96;
    localparam int WAIT_LIMIT = 16;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic        CLK;
    logic        nRST;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic [31:0] instr;
    logic        commit;
    logic        flush_valid;
    ckpt_tag_t   flush_tag;
    logic        pred_valid;
    logic        pred_is_call;
    logic        pred_is_ret;
    logic [31:0] pred_target;
    ckpt_tag_t   alloc_tag;
    logic        ckpt_full;

    // ------------------------------------------------------------------
    // stimulus table, expected class per row
    int          tab_op [MAX_ROWS];
    logic [31:0] tab_pc [MAX_ROWS];
    logic [31:0] tab_instr [MAX_ROWS];
    int          tab_tag [MAX_ROWS];
    logic        tab_call [MAX_ROWS];
    logic        tab_ret [MAX_ROWS];
    int          n_rows;

    // reference model
    logic [31:0] m_stack [`RAS_ENTRIES];
    int          m_slots [`CKPT_ENTRIES];
    int          m_sp;
    int          m_head;
    int          m_tail;
    int          m_count;

    int          seed;
    int          checks;
    int          errors;
    int          timeouts;

    ret_pred_top dut (.*);

    always #5 CLK = ~CLK;

    function automatic logic [31:0] enc_jal(input logic [4:0] rd);
        return {20'h0, rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h0, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    task automatic add_row(input int op, input logic [31:0] word, input int tag,
                           input logic c, input logic r);
        tab_op[n_rows]    = op;
        tab_pc[n_rows]    = $random(seed) & 32'hffff_fffc;
        tab_instr[n_rows] = word;
        tab_tag[n_rows]   = tag;
        tab_call[n_rows]  = c;
        tab_ret[n_rows]   = r;
        n_rows++;
    endtask

    task automatic build_table;
        // nested calls, then returns in reverse order
        add_row(OP_FETCH, enc_jal(5'd1), 0, 1, 0);
        add_row(OP_FETCH, enc_jalr(5'd5, 5'd6), 0, 1, 0);
        add_row(OP_FETCH, enc_jal(5'd1), 0, 1, 0);
        for (int i = 0; i < 3; i++) add_row(OP_COMMIT, NOP, 0, 0, 0);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd1), 0, 0, 1);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd5), 0, 0, 1);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd1), 0, 0, 1);
        for (int i = 0; i < 3; i++) add_row(OP_COMMIT, NOP, 0, 0, 0);
        // no link register involved
        add_row(OP_FETCH, NOP, 0, 0, 0);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd6), 0, 0, 0);
        add_row(OP_FETCH, enc_jalr(5'd7, 5'd8), 0, 0, 0);
        add_row(OP_FETCH, enc_jal(5'd0), 0, 0, 0);
        // call_ret swaps the top, rd == rs1 is a plain call
        add_row(OP_FETCH, enc_jal(5'd1), 0, 1, 0);
        add_row(OP_FETCH, enc_jalr(5'd1, 5'd5), 0, 1, 1);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd1), 0, 0, 1);
        // one more pop reaches the entry below, depth shows here
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd5), 0, 0, 1);
        for (int i = 0; i < 4; i++) add_row(OP_COMMIT, NOP, 0, 0, 0);
        add_row(OP_FETCH, enc_jalr(5'd1, 5'd1), 0, 1, 0);
        add_row(OP_COMMIT, NOP, 0, 0, 0);
        // fill the buffer, then flush back with overwritten entries
        for (int i = 0; i < `CKPT_ENTRIES; i++) add_row(OP_FETCH, enc_jal(5'd1), 0, 1, 0);
        add_row(OP_COMMIT, NOP, 0, 0, 0);
        add_row(OP_FLUSH, 32'd0, 0, 0, 0);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd5), 0, 0, 1);
        add_row(OP_FETCH, enc_jal(5'd5), 0, 1, 0);
        add_row(OP_FLUSH, 32'd0, 1, 0, 0);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd1), 0, 0, 1);
        add_row(OP_COMMIT, NOP, 0, 0, 0);
        // call in the flush cycle must be dropped
        add_row(OP_FLUSH, enc_jal(5'd1), 2, 0, 0);
        add_row(OP_FETCH, enc_jalr(5'd0, 5'd1), 0, 0, 1);
        // last commit hits an empty buffer
        for (int i = 0; i < 5; i++) add_row(OP_COMMIT, NOP, 0, 0, 0);
        // overflow wraps the pointer
        for (int i = 0; i <= `RAS_ENTRIES; i++) begin
            add_row(OP_FETCH, enc_jal(5'd1), 0, 1, 0);
            add_row(OP_COMMIT, NOP, 0, 0, 0);
        end
        for (int i = 0; i <= `RAS_ENTRIES; i++) begin
            add_row(OP_FETCH, enc_jalr(5'd0, 5'd1), 0, 0, 1);
            add_row(OP_COMMIT, NOP, 0, 0, 0);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // idle cycles until a slot is free
    task automatic wait_not_full;
        int   waited;
        logic ready;
        waited = 0;
        ready  = 1'b0;
        while (!ready && waited < WAIT_LIMIT) begin
            @(posedge CLK);
            fetch_valid <= 1'b0;
            commit      <= 1'b0;
            flush_valid <= 1'b0;
            @(negedge CLK);
            ready = !ckpt_full;
            waited++;
        end
        if (!ready) begin
            timeouts++;
            $display("timeout: ckpt_full still high after %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic check_row(input int r);
        logic is_fetch;
        is_fetch = (tab_op[r] == OP_FETCH);
        check_value("ckpt_full", ckpt_full, m_count == `CKPT_ENTRIES);
        // flush rows may carry a fetch that is dropped
        if (tab_op[r] != OP_FLUSH) begin
            check_value("pred_valid", pred_valid, tab_call[r] | tab_ret[r]);
            check_value("pred_is_call", pred_is_call, tab_call[r]);
            check_value("pred_is_ret", pred_is_ret, tab_ret[r]);
        end
        if (is_fetch && tab_ret[r])
            check_value("pred_target", pred_target, m_stack[m_sp]);
        if (is_fetch && (tab_call[r] || tab_ret[r]))
            check_value("alloc_tag", alloc_tag, m_tail);
    endtask

    task automatic update_model(input int r);
        int old_sp;
        old_sp = m_sp;
        if (tab_op[r] == OP_FETCH) begin
            if (tab_call[r] && tab_ret[r]) begin
                m_stack[m_sp] = tab_pc[r] + 32'd4;
            end
            else if (tab_call[r]) begin
                m_sp = (m_sp + 1) % `RAS_ENTRIES;
                m_stack[m_sp] = tab_pc[r] + 32'd4;
            end
            else if (tab_ret[r]) begin
                m_sp = (m_sp + `RAS_ENTRIES - 1) % `RAS_ENTRIES;
            end
            if (tab_call[r] || tab_ret[r]) begin
                m_slots[m_tail] = old_sp;
                m_tail = (m_tail + 1) % `CKPT_ENTRIES;
                m_count++;
            end
        end
        else if (tab_op[r] == OP_COMMIT) begin
            if (m_count != 0) begin
                m_head = (m_head + 1) % `CKPT_ENTRIES;
                m_count--;
            end
        end
        else begin
            // pointer only, stack entries stay as they are
            m_sp    = m_slots[tab_tag[r]];
            m_tail  = (tab_tag[r] + 1) % `CKPT_ENTRIES;
            m_count = (m_tail - m_head + `CKPT_ENTRIES) % `CKPT_ENTRIES;
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    initial begin
        seed        = 32'h3b3f;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        n_rows      = 0;
        CLK         = 1'b0;
        nRST        = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        instr       = '0;
        commit      = 1'b0;
        flush_valid = 1'b0;
        flush_tag   = '0;
        m_sp        = 0;
        m_head      = 0;
        m_tail      = 0;
        m_count     = 0;
        for (int i = 0; i < `RAS_ENTRIES; i++) m_stack[i] = '0;
        build_table();

        for (int i = 0; i < 8; i++) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_value("pred_valid", pred_valid, 0);
        check_value("ckpt_full", ckpt_full, 0);
        check_value("alloc_tag", alloc_tag, 0);

        for (int r = 0; r < n_rows && timeouts == 0; r++) begin
            if (tab_call[r] || tab_ret[r])
                wait_not_full();
            if (timeouts == 0) begin
                @(posedge CLK);
                fetch_valid <= (tab_op[r] == OP_FETCH) ||
                               (tab_op[r] == OP_FLUSH && tab_instr[r] != 32'd0);
                fetch_pc    <= tab_pc[r];
                instr       <= tab_instr[r];
                commit      <= (tab_op[r] == OP_COMMIT);
                flush_valid <= (tab_op[r] == OP_FLUSH);
                flush_tag   <= ckpt_tag_t'(tab_tag[r]);
                // outputs settle well before the falling edge
                @(negedge CLK);
                check_row(r);
                update_model(r);
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/ret_pred_pkg.sv
hw/ras_port_if.sv
hw/ret_predecode.sv
hw/ras.sv
hw/ras_ckpt_buf.sv
hw/ret_pred_top.sv
sim/ret_pred_props.sv
sim/ret_pred_tb.sv
